/* hw/axi_ic_pkg.sv */
package axi_ic_pkg;

    // Bus widths
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int TRANS_ID_W     = 5;
    localparam int MST_IDX_W      = 2;
    localparam int SLV_TRANS_ID_W = TRANS_ID_W + MST_IDX_W;
    localparam int LEN_W          = 3;
    localparam int BURST_W        = 2;
    localparam int SIZE_W         = 3;

    // Address bit that picks slave 0 or slave 1
    localparam int SLV_SEL_BIT    = 30;

    // One weight, one credit counter
    localparam int WEIGHT_W       = 4;

    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [DATA_W-1:0]         data_t;
    typedef logic [TRANS_ID_W-1:0]     trans_id_t;
    typedef logic [SLV_TRANS_ID_W-1:0] slv_trans_id_t;
    typedef logic [LEN_W-1:0]          len_t;
    typedef logic [BURST_W-1:0]        burst_t;
    typedef logic [SIZE_W-1:0]         size_t;
    typedef logic [MST_IDX_W-1:0]      mst_idx_t;

    // Slave-side ID is {master index, master transaction ID}
    function automatic slv_trans_id_t make_slv_id(mst_idx_t mst, trans_id_t id);
        return {mst, id};
    endfunction

    function automatic mst_idx_t slv_id_mst(slv_trans_id_t id);
        return id[SLV_TRANS_ID_W-1 -: MST_IDX_W];
    endfunction

    function automatic trans_id_t slv_id_trans(slv_trans_id_t id);
        return id[TRANS_ID_W-1:0];
    endfunction

endpackage

/* hw/weighted_rr_arbiter.sv */
`timescale 1ns/1ns

module weighted_rr_arbiter #(
    parameter int MST_AMT = 4,
    parameter logic [MST_AMT-1:0][axi_ic_pkg::WEIGHT_W-1:0] MST_WEIGHT =
        {4'd1, 4'd2, 4'd3, 4'd5}
) (
    input  logic               aclk_i,
    input  logic               arst_n_i,
    input  logic [MST_AMT-1:0] req_i,
    input  logic               advance_i,
    output logic [MST_AMT-1:0] gnt_o
);

    import axi_ic_pkg::*;

    localparam int PTR_W = (MST_AMT > 1) ? $clog2(MST_AMT) : 1;

    logic [PTR_W-1:0]                   ptr_q;
    logic [PTR_W-1:0]                   ptr_next;
    logic [MST_AMT-1:0][WEIGHT_W-1:0]   credit_q;
    logic [PTR_W-1:0]                   gnt_idx;
    logic                               found;
    logic                               ptr_hit;
    logic                               last_credit;

    // First requester from the pointer upward, wrapping
    always_comb begin
        gnt_idx = ptr_q;
        found   = 1'b0;
        for (int i = 0; i < MST_AMT; i++) begin
            if (!found && req_i[(int'(ptr_q) + i) % MST_AMT]) begin
                found   = 1'b1;
                gnt_idx = PTR_W'((int'(ptr_q) + i) % MST_AMT);
            end
        end
    end

    assign gnt_o       = found ? (MST_AMT'(1) << gnt_idx) : '0;
    assign ptr_hit     = req_i[ptr_q];
    assign last_credit = (credit_q[gnt_idx] <= WEIGHT_W'(1));
    assign ptr_next    = (ptr_q == PTR_W'(MST_AMT - 1)) ? '0 : ptr_q + 1'b1;

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q    <= '0;
            credit_q <= MST_WEIGHT;
        end else if (advance_i && found) begin
            for (int i = 0; i < MST_AMT; i++) begin
                if (i == int'(gnt_idx)) begin
                    // Granted master spends one credit, refills when empty
                    if (last_credit) begin
                        credit_q[i] <= MST_WEIGHT[i];
                    end else begin
                        credit_q[i] <= credit_q[i] - 1'b1;
                    end
                end else if (!ptr_hit && i == int'(ptr_q)) begin
                    // Idle pointer master gives up its turn
                    credit_q[i] <= MST_WEIGHT[i];
                end
            end
            if (!ptr_hit || last_credit) begin
                ptr_q <= ptr_next;
            end
        end
    end

endmodule

/* hw/ar_slave_arbiter.sv */
`timescale 1ns/1ns

module ar_slave_arbiter #(
    parameter int MST_AMT = 4,
    parameter int SLV_ID  = 0,
    parameter logic [MST_AMT-1:0][axi_ic_pkg::WEIGHT_W-1:0] MST_WEIGHT =
        {4'd1, 4'd2, 4'd3, 4'd5}
) (
    input  logic                                  aclk_i,
    input  logic                                  arst_n_i,
    // Master side
    input  axi_ic_pkg::trans_id_t [MST_AMT-1:0]   m_arid_i,
    input  axi_ic_pkg::addr_t     [MST_AMT-1:0]   m_araddr_i,
    input  axi_ic_pkg::burst_t    [MST_AMT-1:0]   m_arburst_i,
    input  axi_ic_pkg::len_t      [MST_AMT-1:0]   m_arlen_i,
    input  axi_ic_pkg::size_t     [MST_AMT-1:0]   m_arsize_i,
    input  logic                  [MST_AMT-1:0]   m_arvalid_i,
    output logic                  [MST_AMT-1:0]   gnt_o,
    // Slave side
    input  logic                                  s_arready_i,
    output axi_ic_pkg::slv_trans_id_t             s_arid_o,
    output axi_ic_pkg::addr_t                     s_araddr_o,
    output axi_ic_pkg::burst_t                    s_arburst_o,
    output axi_ic_pkg::len_t                      s_arlen_o,
    output axi_ic_pkg::size_t                     s_arsize_o,
    output logic                                  s_arvalid_o
);

    import axi_ic_pkg::*;

    logic [MST_AMT-1:0] req;
    logic               can_load;
    logic               load;
    mst_idx_t           sel_idx;

    // Output register is free, or the slave takes it this cycle
    assign can_load = !s_arvalid_o || s_arready_i;

    // Only masters addressing this slave, and only when a slot is open
    always_comb begin
        for (int m = 0; m < MST_AMT; m++) begin
            req[m] = can_load && m_arvalid_i[m]
                     && (m_araddr_i[m][SLV_SEL_BIT] == 1'(SLV_ID));
        end
    end

    assign load = |req;

    weighted_rr_arbiter #(
        .MST_AMT    (MST_AMT),
        .MST_WEIGHT (MST_WEIGHT)
    ) wrr0 (
        .aclk_i    (aclk_i),
        .arst_n_i  (arst_n_i),
        .req_i     (req),
        .advance_i (load),
        .gnt_o     (gnt_o)
    );

    // One-hot grant to index
    always_comb begin
        sel_idx = '0;
        for (int m = 0; m < MST_AMT; m++) begin
            if (gnt_o[m]) begin
                sel_idx = mst_idx_t'(m);
            end
        end
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_arvalid_o <= 1'b0;
        end else if (can_load) begin
            s_arvalid_o <= load;
        end
    end

    // Request payload, master index goes above the transaction ID
    always_ff @(posedge aclk_i) begin
        if (load) begin
            s_arid_o    <= make_slv_id(sel_idx, m_arid_i[sel_idx]);
            s_araddr_o  <= m_araddr_i[sel_idx];
            s_arburst_o <= m_arburst_i[sel_idx];
            s_arlen_o   <= m_arlen_i[sel_idx];
            s_arsize_o  <= m_arsize_i[sel_idx];
        end
    end

endmodule

/* hw/r_return_router.sv */
`timescale 1ns/1ns

module r_return_router #(
    parameter int MST_AMT = 4,
    parameter int SLV_AMT = 2
) (
    input  logic                                      aclk_i,
    input  logic                                      arst_n_i,
    // Slave side
    input  axi_ic_pkg::slv_trans_id_t [SLV_AMT-1:0]   s_rid_i,
    input  axi_ic_pkg::data_t         [SLV_AMT-1:0]   s_rdata_i,
    input  logic                      [SLV_AMT-1:0]   s_rlast_i,
    input  logic                      [SLV_AMT-1:0]   s_rvalid_i,
    output logic                      [SLV_AMT-1:0]   s_rready_o,
    // Master side
    output axi_ic_pkg::trans_id_t     [MST_AMT-1:0]   m_rid_o,
    output axi_ic_pkg::data_t         [MST_AMT-1:0]   m_rdata_o,
    output logic                      [MST_AMT-1:0]   m_rlast_o,
    output logic                      [MST_AMT-1:0]   m_rvalid_o,
    input  logic                      [MST_AMT-1:0]   m_rready_i
);

    import axi_ic_pkg::*;

    localparam int SLV_IDX_W = (SLV_AMT > 1) ? $clog2(SLV_AMT) : 1;

    logic [MST_AMT-1:0]                  busy_q;
    logic [MST_AMT-1:0][SLV_IDX_W-1:0]   owner_q;
    logic [MST_AMT-1:0][SLV_AMT-1:0]     hit;
    logic [MST_AMT-1:0][SLV_IDX_W-1:0]   sel;
    logic [MST_AMT-1:0]                  act;

    // Which slaves hold a beat for which master
    always_comb begin
        for (int m = 0; m < MST_AMT; m++) begin
            for (int s = 0; s < SLV_AMT; s++) begin
                hit[m][s] = s_rvalid_i[s] && (slv_id_mst(s_rid_i[s]) == mst_idx_t'(m));
            end
        end
    end

    // Open burst keeps its owner, otherwise lowest slave index wins
    always_comb begin
        for (int m = 0; m < MST_AMT; m++) begin
            sel[m] = owner_q[m];
            act[m] = hit[m][owner_q[m]];
            if (!busy_q[m]) begin
                act[m] = |hit[m];
                for (int s = SLV_AMT - 1; s >= 0; s--) begin
                    if (hit[m][s]) begin
                        sel[m] = SLV_IDX_W'(s);
                    end
                end
            end
        end
    end

    always_comb begin
        s_rready_o = '0;
        for (int m = 0; m < MST_AMT; m++) begin
            m_rvalid_o[m] = act[m];
            m_rdata_o[m]  = s_rdata_i[sel[m]];
            m_rid_o[m]    = slv_id_trans(s_rid_i[sel[m]]);
            m_rlast_o[m]  = act[m] && s_rlast_i[sel[m]];
            // Ready back to the forwarding slave only
            if (act[m] && m_rready_i[m]) begin
                s_rready_o[sel[m]] = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= '0;
            owner_q <= '0;
        end else begin
            for (int m = 0; m < MST_AMT; m++) begin
                if (act[m] && m_rready_i[m]) begin
                    busy_q[m]  <= !m_rlast_o[m];
                    owner_q[m] <= sel[m];
                end
            end
        end
    end

endmodule

/* hw/axi_read_interconnect.sv */
`timescale 1ns/1ns

module axi_read_interconnect #(
    parameter int MST_AMT = 4,
    parameter int SLV_AMT = 2,
    parameter logic [MST_AMT-1:0][axi_ic_pkg::WEIGHT_W-1:0] MST_WEIGHT =
        {4'd1, 4'd2, 4'd3, 4'd5}
) (
    input  logic                                      aclk_i,
    input  logic                                      arst_n_i,
    // Master AR
    input  axi_ic_pkg::trans_id_t     [MST_AMT-1:0]   m_arid_i,
    input  axi_ic_pkg::addr_t         [MST_AMT-1:0]   m_araddr_i,
    input  axi_ic_pkg::burst_t        [MST_AMT-1:0]   m_arburst_i,
    input  axi_ic_pkg::len_t          [MST_AMT-1:0]   m_arlen_i,
    input  axi_ic_pkg::size_t         [MST_AMT-1:0]   m_arsize_i,
    input  logic                      [MST_AMT-1:0]   m_arvalid_i,
    output logic                      [MST_AMT-1:0]   m_arready_o,
    // Master R
    output axi_ic_pkg::trans_id_t     [MST_AMT-1:0]   m_rid_o,
    output axi_ic_pkg::data_t         [MST_AMT-1:0]   m_rdata_o,
    output logic                      [MST_AMT-1:0]   m_rlast_o,
    output logic                      [MST_AMT-1:0]   m_rvalid_o,
    input  logic                      [MST_AMT-1:0]   m_rready_i,
    // Slave AR
    output axi_ic_pkg::slv_trans_id_t [SLV_AMT-1:0]   s_arid_o,
    output axi_ic_pkg::addr_t         [SLV_AMT-1:0]   s_araddr_o,
    output axi_ic_pkg::burst_t        [SLV_AMT-1:0]   s_arburst_o,
    output axi_ic_pkg::len_t          [SLV_AMT-1:0]   s_arlen_o,
    output axi_ic_pkg::size_t         [SLV_AMT-1:0]   s_arsize_o,
    output logic                      [SLV_AMT-1:0]   s_arvalid_o,
    input  logic                      [SLV_AMT-1:0]   s_arready_i,
    // Slave R
    input  axi_ic_pkg::slv_trans_id_t [SLV_AMT-1:0]   s_rid_i,
    input  axi_ic_pkg::data_t         [SLV_AMT-1:0]   s_rdata_i,
    input  logic                      [SLV_AMT-1:0]   s_rlast_i,
    input  logic                      [SLV_AMT-1:0]   s_rvalid_i,
    output logic                      [SLV_AMT-1:0]   s_rready_o
);

    logic [MST_AMT-1:0] arb0_gnt;
    logic [MST_AMT-1:0] arb1_gnt;

    // A master's address selects one slave, so at most one grant per master
    assign m_arready_o = arb0_gnt | arb1_gnt;

    ar_slave_arbiter #(
        .MST_AMT    (MST_AMT),
        .SLV_ID     (0),
        .MST_WEIGHT (MST_WEIGHT)
    ) arb0 (
        .aclk_i      (aclk_i),
        .arst_n_i    (arst_n_i),
        .m_arid_i    (m_arid_i),
        .m_araddr_i  (m_araddr_i),
        .m_arburst_i (m_arburst_i),
        .m_arlen_i   (m_arlen_i),
        .m_arsize_i  (m_arsize_i),
        .m_arvalid_i (m_arvalid_i),
        .gnt_o       (arb0_gnt),
        .s_arready_i (s_arready_i[0]),
        .s_arid_o    (s_arid_o[0]),
        .s_araddr_o  (s_araddr_o[0]),
        .s_arburst_o (s_arburst_o[0]),
        .s_arlen_o   (s_arlen_o[0]),
        .s_arsize_o  (s_arsize_o[0]),
        .s_arvalid_o (s_arvalid_o[0])
    );

    ar_slave_arbiter #(
        .MST_AMT    (MST_AMT),
        .SLV_ID     (1),
        .MST_WEIGHT (MST_WEIGHT)
    ) arb1 (
        .aclk_i      (aclk_i),
        .arst_n_i    (arst_n_i),
        .m_arid_i    (m_arid_i),
        .m_araddr_i  (m_araddr_i),
        .m_arburst_i (m_arburst_i),
        .m_arlen_i   (m_arlen_i),
        .m_arsize_i  (m_arsize_i),
        .m_arvalid_i (m_arvalid_i),
        .gnt_o       (arb1_gnt),
        .s_arready_i (s_arready_i[1]),
        .s_arid_o    (s_arid_o[1]),
        .s_araddr_o  (s_araddr_o[1]),
        .s_arburst_o (s_arburst_o[1]),
        .s_arlen_o   (s_arlen_o[1]),
        .s_arsize_o  (s_arsize_o[1]),
        .s_arvalid_o (s_arvalid_o[1])
    );

    r_return_router #(
        .MST_AMT (MST_AMT),
        .SLV_AMT (SLV_AMT)
    ) rtr0 (
        .aclk_i     (aclk_i),
        .arst_n_i   (arst_n_i),
        .s_rid_i    (s_rid_i),
        .s_rdata_i  (s_rdata_i),
        .s_rlast_i  (s_rlast_i),
        .s_rvalid_i (s_rvalid_i),
        .s_rready_o (s_rready_o),
        .m_rid_o    (m_rid_o),
        .m_rdata_o  (m_rdata_o),
        .m_rlast_o  (m_rlast_o),
        .m_rvalid_o (m_rvalid_o),
        .m_rready_i (m_rready_i)
    );

endmodule

/* tb/axi_read_interconnect_tb.sv */
`timescale 1ns/1ns

module axi_read_interconnect_tb;

    import axi_ic_pkg::*;

    localparam int N_TRANS   = 60;
    localparam int WATCH_CYC = 40 + N_TRANS * 8 * 4 + 500;
    localparam int WEIGHT [4] = '{5, 3, 2, 1};

    logic aclk_i = 1'b0;
    logic arst_n_i;
    trans_id_t     [3:0] m_arid_i;
    trans_id_t     [3:0] m_rid_o;
    addr_t         [3:0] m_araddr_i;
    burst_t        [3:0] m_arburst_i;
    len_t          [3:0] m_arlen_i;
    size_t         [3:0] m_arsize_i;
    data_t         [3:0] m_rdata_o;
    logic          [3:0] m_arvalid_i;
    logic          [3:0] m_arready_o;
    logic          [3:0] m_rlast_o;
    logic          [3:0] m_rvalid_o;
    logic          [3:0] m_rready_i;
    slv_trans_id_t [1:0] s_arid_o;
    slv_trans_id_t [1:0] s_rid_i;
    addr_t         [1:0] s_araddr_o;
    burst_t        [1:0] s_arburst_o;
    len_t          [1:0] s_arlen_o;
    size_t         [1:0] s_arsize_o;
    data_t         [1:0] s_rdata_i;
    logic          [1:0] s_arvalid_o;
    logic          [1:0] s_arready_i;
    logic          [1:0] s_rlast_i;
    logic          [1:0] s_rvalid_i;
    logic          [1:0] s_rready_o;

    // AR entry is {id, addr, len, burst, size}
    // R entry is {id, addr, len}
    logic [46:0] exp_ar [2][$];
    logic [41:0] slv_q [2][$];
    logic [39:0] exp_r [4][$];
    logic [39:0] cur [4];
    logic [3:0]  cur_act;
    int          beat [4];
    logic [46:0] held_val [2];
    logic [1:0]  held;

    logic [31:0] lfsr = 32'h522a54e3;
    int     errors = 0;
    int     ar_cnt = 0;
    int     r_cnt = 0;
    int     tid_cnt = 0;
    int     mdl_ptr;
    int     mdl_cred [4];
    string  test_name = "reset";
    logic   check_order = 1'b0;
    logic   resp_hold = 1'b0;
    logic   rnd_ar = 1'b0;
    logic   rnd_r = 1'b0;

    axi_read_interconnect #(.MST_AMT(4), .SLV_AMT(2)) dut0 (.*);

    always #5 aclk_i = ~aclk_i;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rnd_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    function automatic data_t beat_data(input addr_t addr, input int b);
        return addr ^ 32'(b);
    endfunction

    function automatic slv_trans_id_t exp_slv_id(input int m, input trans_id_t id);
        return slv_trans_id_t'((m << TRANS_ID_W) | int'(id));
    endfunction

    // Weighted round robin reference that updates its own state per grant
    function automatic int model_grant(input logic [3:0] req);
        int g;
        int p;
        g = -1;
        p = mdl_ptr;
        for (int i = 0; i < 4; i++) begin
            if (g < 0 && req[(p + i) % 4]) g = (p + i) % 4;
        end
        if (g >= 0) begin
            mdl_cred[g]--;
            if (mdl_cred[g] == 0) mdl_cred[g] = WEIGHT[g];
            if (!req[p]) mdl_cred[p] = WEIGHT[p];
            if (mdl_cred[g] == WEIGHT[g] || !req[p]) mdl_ptr = (p + 1) % 4;
        end
        return g;
    endfunction

    function automatic logic all_idle();
        return exp_ar[0].size() == 0 && exp_ar[1].size() == 0 && cur_act == '0
            && exp_r[0].size() == 0 && exp_r[1].size() == 0
            && exp_r[2].size() == 0 && exp_r[3].size() == 0;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] e, input logic [63:0] a);
        errors++;
        $display("CHECK FAILED %s/%s: expected %h, actual %h", test_name, what, e, a);
    endtask

    task automatic apply_reset();
        arst_n_i = 1'b0;
        mdl_ptr  = 0;
        for (int i = 0; i < 4; i++) mdl_cred[i] = WEIGHT[i];
        repeat (10) @(posedge aclk_i);
        #1 arst_n_i = 1'b1;
    endtask

    // Called 1 ns after an edge and returns 1 ns after the handshake edge
    task automatic issue_ar(input int m, input logic sel, input len_t len);
        trans_id_t id;
        addr_t     addr;
        burst_t    burst;
        size_t     size;
        id = trans_id_t'(tid_cnt);
        tid_cnt++;
        addr = rnd_bits(32);
        addr[SLV_SEL_BIT] = sel;
        burst = burst_t'(rnd_bits(2));
        size = size_t'(rnd_bits(3));
        exp_ar[sel].push_back({exp_slv_id(m, id), addr, len, burst, size});
        exp_r[m].push_back({id, addr, len});
        m_arid_i[m]    = id;
        m_araddr_i[m]  = addr;
        m_arburst_i[m] = burst;
        m_arlen_i[m]   = len;
        m_arsize_i[m]  = size;
        m_arvalid_i[m] = 1'b1;
        @(posedge aclk_i);
        while (!m_arready_o[m]) @(posedge aclk_i);
        #1 m_arvalid_i[m] = 1'b0;
    endtask

    // Queues are sampled away from the clock edge
    task automatic drain();
        @(negedge aclk_i);
        while (!all_idle()) @(negedge aclk_i);
        @(posedge aclk_i);
        #1;
    endtask

    // Slave model returns len+1 beats per accepted request in order
    task automatic serve_slave(input int s);
        logic [41:0] rq;
        forever begin
            @(posedge aclk_i);
            #1;
            if (slv_q[s].size() > 0 && !resp_hold) begin
                rq = slv_q[s].pop_front();
                for (int b = 0; b <= int'(rq[2:0]); b++) begin
                    s_rid_i[s]    = rq[41:35];
                    s_rdata_i[s]  = beat_data(rq[34:3], b);
                    s_rlast_i[s]  = (b == int'(rq[2:0]));
                    s_rvalid_i[s] = 1'b1;
                    @(posedge aclk_i);
                    while (!s_rready_o[s]) @(posedge aclk_i);
                    #1;
                end
                s_rvalid_i[s] = 1'b0;
            end
        end
    endtask

    initial serve_slave(0);
    initial serve_slave(1);

    always @(posedge aclk_i) begin
        #1;
        s_arready_i = rnd_ar ? 2'(rnd_bits(2)) : 2'b11;
        m_rready_i  = rnd_r ? 4'(rnd_bits(4)) : 4'hf;
    end

    // Comparing process
    always @(posedge aclk_i) begin : compare_proc
        logic [46:0] got;
        int idx;
        int g;
        int mst;
        if (arst_n_i) begin
            for (int s = 0; s < 2; s++) begin
                got = {s_arid_o[s], s_araddr_o[s], s_arlen_o[s], s_arburst_o[s], s_arsize_o[s]};
                if (held[s] && got != held_val[s]) begin
                    report_mismatch("ar_hold", 64'(held_val[s]), 64'(got));
                end
                held[s] = s_arvalid_o[s] && !s_arready_i[s];
                held_val[s] = got;
                for (int m = 0; m < 4; m++) begin
                    if (held[s] && m_arready_o[m] && m_araddr_i[m][SLV_SEL_BIT] == s[0]) begin
                        errors++;
                        $display("Master %0d got ARREADY while slave %0d was stalled", m, s);
                    end
                end
                if (s_arvalid_o[s] && s_arready_i[s]) begin
                    ar_cnt++;
                    slv_q[s].push_back({s_arid_o[s], s_araddr_o[s], s_arlen_o[s]});
                    idx = -1;
                    for (int i = 0; i < exp_ar[s].size(); i++) begin
                        if (idx < 0 && exp_ar[s][i] == got) idx = i;
                    end
                    if (idx < 0) begin
                        report_mismatch($sformatf("ar_s%0d", s),
                                        exp_ar[s].size() > 0 ? 64'(exp_ar[s][0]) : 64'(0),
                                        64'(got));
                    end else begin
                        exp_ar[s].delete(idx);
                    end
                    if (check_order && s == 0) begin
                        g = model_grant(4'hf);
                        mst = int'(s_arid_o[0][TRANS_ID_W +: MST_IDX_W]);
                        if (mst != g) begin
                            report_mismatch("grant", 64'(g), 64'(mst));
                        end
                    end
                end
            end
            for (int m = 0; m < 4; m++) begin
                if (m_rvalid_o[m] && m_rready_i[m]) begin
                    r_cnt++;
                    if (!cur_act[m]) begin
                        idx = -1;
                        for (int i = 0; i < exp_r[m].size(); i++) begin
                            if (idx < 0 && exp_r[m][i][39:35] == m_rid_o[m]
                                && exp_r[m][i][34:3] == m_rdata_o[m]) idx = i;
                        end
                        if (idx < 0) begin
                            errors++;
                            $display("Master %0d got a beat that starts no expected burst", m);
                        end else begin
                            cur[m] = exp_r[m][idx];
                            exp_r[m].delete(idx);
                            cur_act[m] = 1'b1;
                            beat[m] = 0;
                        end
                    end
                    if (cur_act[m]) begin
                        if (m_rdata_o[m] != beat_data(cur[m][34:3], beat[m])) begin
                            report_mismatch("r_data", 64'(beat_data(cur[m][34:3], beat[m])),
                                            64'(m_rdata_o[m]));
                        end
                        if (m_rid_o[m] != cur[m][39:35]) begin
                            report_mismatch("r_id", 64'(cur[m][39:35]), 64'(m_rid_o[m]));
                        end
                        if (m_rlast_o[m] != (beat[m] == int'(cur[m][2:0]))) begin
                            report_mismatch("r_last", 64'(beat[m] == int'(cur[m][2:0])),
                                            64'(m_rlast_o[m]));
                        end
                        if (beat[m] == int'(cur[m][2:0])) cur_act[m] = 1'b0;
                        else beat[m]++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCH_CYC * 10);
        $display("Timeout: the run did not finish within %0d cycles", WATCH_CYC);
        $display("Test failed");
        $finish;
    end

    initial begin
        m_arid_i = '0;
        m_araddr_i = '0;
        m_arburst_i = '0;
        m_arlen_i = '0;
        m_arsize_i = '0;
        m_arvalid_i = '0;
        m_rready_i = '1;
        s_arready_i = '1;
        s_rid_i = '0;
        s_rdata_i = '0;
        s_rlast_i = '0;
        s_rvalid_i = '0;
        cur_act = '0;
        held = '0;
        apply_reset();

        test_name = "decode";
        for (int m = 0; m < 4; m++) begin
            issue_ar(m, 1'b0, len_t'(m));
            issue_ar(m, 1'b1, len_t'(m + 1));
        end
        drain();

        // Fresh arbiter state for the weighted order
        test_name = "weighted_order";
        apply_reset();
        check_order = 1'b1;
        fork
            for (int k = 0; k < 10; k++) issue_ar(0, 1'b0, 3'd0);
            for (int k = 0; k < 6; k++) issue_ar(1, 1'b0, 3'd0);
            for (int k = 0; k < 4; k++) issue_ar(2, 1'b0, 3'd0);
            for (int k = 0; k < 2; k++) issue_ar(3, 1'b0, 3'd0);
        join
        drain();
        check_order = 1'b0;

        test_name = "ar_backpressure";
        rnd_ar = 1'b1;
        for (int m = 0; m < 4; m++) begin
            fork
                automatic int mm = m;
                repeat (2) issue_ar(mm, 1'b0, len_t'(rnd_bits(3)));
            join_none
        end
        wait fork;
        #1 rnd_ar = 1'b0;
        drain();

        test_name = "read_routing";
        for (int m = 0; m < 4; m++) begin
            fork
                automatic int mm = m;
                repeat (4) issue_ar(mm, 1'(rnd_bits(1)), len_t'(rnd_bits(3)));
            join_none
        end
        wait fork;
        drain();

        test_name = "contention";
        rnd_r = 1'b1;
        for (int k = 0; k < 3; k++) begin
            resp_hold = 1'b1;
            issue_ar(k + 1, 1'b0, 3'd7);
            issue_ar(k + 1, 1'b1, len_t'(rnd_bits(3)));
            // Both slaves start answering on the same edge
            @(negedge aclk_i);
            while (slv_q[0].size() == 0 || slv_q[1].size() == 0) @(negedge aclk_i);
            resp_hold = 1'b0;
            drain();
        end
        rnd_r = 1'b0;

        $display("Errors: %0d, AR transfers: %0d, R beats: %0d", errors, ar_cnt, r_cnt);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
hw/axi_ic_pkg.sv
hw/weighted_rr_arbiter.sv
hw/ar_slave_arbiter.sv
hw/r_return_router.sv
hw/axi_read_interconnect.sv
tb/axi_read_interconnect_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= axi_read_interconnect_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "Test completed successfully" $(LOG) || { echo "No pass message"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
